//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module csrUnitTb -f all.f
	out="$$(./obj_dir/VcsrUnitTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

//--- all.f
design/csrPkg.sv
design/csrCmdDecode.sv
design/csrCmdFifo.sv
design/supervisorCsrs.sv
design/csrUnit.sv
verif/tbClock.sv
verif/csrUnitTb.sv

//--- design/csrCmdDecode.sv
module csrCmdDecode #(
  parameter bit VirtMem = 1'b1
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    cmdValid,
  output logic                    cmdReady,
  input  csrPkg::csrOpT           cmdOp,
  input  logic [11:0]             cmdAdr,
  input  csrPkg::privT            cmdPriv,
  input  logic [csrPkg::xlen-1:0] cmdData,
  input  logic [csrPkg::xlen-1:0] cmdCause,
  input  logic [csrPkg::xlen-1:0] cmdTval,
  input  logic                    statusTvm,
  output logic                    decValid,
  input  logic                    decReady,
  output csrPkg::csrOpT           decOp,
  output csrPkg::regIdxT          decIdx,
  output logic                    decIllegal,
  output logic [csrPkg::xlen-1:0] decData,
  output logic [csrPkg::xlen-1:0] decCause,
  output logic [csrPkg::xlen-1:0] decTval
);
  import csrPkg::*;

  regIdxT adrIdx;
  logic   isSatp;
  logic   privLow;
  logic   tvmBlock;
  logic   satpOff;
  logic   illegal;
  logic   load;

  // Address to register index
  always_comb begin
    case (cmdAdr)
      adrStvec:      adrIdx = regStvec;
      adrSscratch:   adrIdx = regSscratch;
      adrSepc:       adrIdx = regSepc;
      adrScause:     adrIdx = regScause;
      adrStval:      adrIdx = regStval;
      adrSatp:       adrIdx = regSatp;
      adrScounteren: adrIdx = regScounteren;
      adrSedeleg:    adrIdx = regSedeleg;
      adrSideleg:    adrIdx = regSideleg;
      default:       adrIdx = regNone;
    endcase
  end

  // Legality checks, traps are never flagged
  assign isSatp   = (adrIdx == regSatp);
  assign privLow  = (cmdPriv == privU);
  // TVM only traps satp below machine mode
  assign tvmBlock = isSatp && statusTvm && (cmdPriv != privM);
  assign satpOff  = isSatp && !VirtMem;
  assign illegal  = (cmdOp != opTrap) &&
                    ((adrIdx == regNone) || privLow || tvmBlock || satpOff);

  // Stage is free when empty or draining this edge
  assign cmdReady = !decValid || decReady;
  assign load     = cmdValid && cmdReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decValid <= 1'b0;
    end else if (load) begin
      decValid <= 1'b1;
    end else if (decReady) begin
      decValid <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (load) begin
      decOp      <= cmdOp;
      decIdx     <= illegal ? regNone : adrIdx;
      decIllegal <= illegal;
      decData    <= cmdData;
      decCause   <= cmdCause;
      decTval    <= cmdTval;
    end
  end

  // Decoded entry waits for the FIFO
  assert property (@(posedge clk) disable iff (!rstN)
    decValid && !decReady |=> decValid && $stable(decData));

endmodule

//--- design/csrCmdFifo.sv
module csrCmdFifo #(
  parameter int FifoDepth = 4
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    decValid,
  output logic                    decReady,
  input  csrPkg::csrOpT           decOp,
  input  csrPkg::regIdxT          decIdx,
  input  logic                    decIllegal,
  input  logic [csrPkg::xlen-1:0] decData,
  input  logic [csrPkg::xlen-1:0] decCause,
  input  logic [csrPkg::xlen-1:0] decTval,
  output logic                    fifoValid,
  input  logic                    fifoReady,
  output csrPkg::csrOpT           fifoOp,
  output csrPkg::regIdxT          fifoIdx,
  output logic                    fifoIllegal,
  output logic [csrPkg::xlen-1:0] fifoData,
  output logic [csrPkg::xlen-1:0] fifoCause,
  output logic [csrPkg::xlen-1:0] fifoTval
);
  import csrPkg::*;

  localparam int ptrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int cntW = $clog2(FifoDepth + 1);

  // Entry storage
  csrOpT           opMem    [FifoDepth];
  regIdxT          idxMem   [FifoDepth];
  logic            illMem   [FifoDepth];
  logic [xlen-1:0] dataMem  [FifoDepth];
  logic [xlen-1:0] causeMem [FifoDepth];
  logic [xlen-1:0] tvalMem  [FifoDepth];

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic            push;
  logic            pop;

  // Pointer wrap for any depth
  function automatic logic [ptrW-1:0] bump(input logic [ptrW-1:0] p);
    return (p == ptrW'(FifoDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign decReady  = (count != cntW'(FifoDepth));
  assign fifoValid = (count != '0);
  assign push      = decValid && decReady;
  assign pop       = fifoValid && fifoReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= bump(wrPtr);
      if (pop) rdPtr <= bump(rdPtr);
      // Occupancy
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      opMem[wrPtr]    <= decOp;
      idxMem[wrPtr]   <= decIdx;
      illMem[wrPtr]   <= decIllegal;
      dataMem[wrPtr]  <= decData;
      causeMem[wrPtr] <= decCause;
      tvalMem[wrPtr]  <= decTval;
    end
  end

  // Head entry
  assign fifoOp      = opMem[rdPtr];
  assign fifoIdx     = idxMem[rdPtr];
  assign fifoIllegal = illMem[rdPtr];
  assign fifoData    = dataMem[rdPtr];
  assign fifoCause   = causeMem[rdPtr];
  assign fifoTval    = tvalMem[rdPtr];

  // Occupancy never goes past the depth, so no push on full and no pop on empty
  assert property (@(posedge clk) disable iff (!rstN)
    count <= cntW'(FifoDepth));
  // Pointers only meet on an empty or a full buffer
  assert property (@(posedge clk) disable iff (!rstN)
    (wrPtr == rdPtr) == (count == '0 || count == cntW'(FifoDepth)));

endmodule

//--- design/csrPkg.sv
package csrPkg;

  //////////////////////////////
  // Widths and constants
  //////////////////////////////

  // Fixed data width for this unit
  parameter int xlen = 64;

  // Supervisor CSR addresses
  parameter logic [11:0] adrSedeleg    = 12'h102;
  parameter logic [11:0] adrSideleg    = 12'h103;
  parameter logic [11:0] adrStvec      = 12'h105;
  parameter logic [11:0] adrScounteren = 12'h106;
  parameter logic [11:0] adrSscratch   = 12'h140;
  parameter logic [11:0] adrSepc       = 12'h141;
  parameter logic [11:0] adrScause     = 12'h142;
  parameter logic [11:0] adrStval      = 12'h143;
  parameter logic [11:0] adrSatp       = 12'h180;

  // Bits 11:9 of sedeleg are hardwired to zero
  parameter logic [xlen-1:0] sedelegMask = ~(64'h7 << 9);

  //////////////////////////////
  // Command encodings
  //////////////////////////////

  // Three CSR access flavours plus trap entry
  typedef enum logic [1:0] {
    opRw   = 2'b00,
    opRs   = 2'b01,
    opRc   = 2'b10,
    opTrap = 2'b11
  } csrOpT;

  // Privilege levels, H encoding left out
  typedef enum logic [1:0] {
    privU = 2'b00,
    privS = 2'b01,
    privM = 2'b11
  } privT;

  // Register file index, regNone marks an illegal access
  typedef enum logic [3:0] {
    regStvec,
    regSscratch,
    regSepc,
    regScause,
    regStval,
    regSatp,
    regScounteren,
    regSedeleg,
    regSideleg,
    regNone
  } regIdxT;

  // Stvec seen as a raw word or as base and mode
  typedef union packed {
    logic [xlen-1:0] raw;
    struct packed {
      logic [xlen-3:0] base;
      logic [1:0]      mode;
    } f;
  } stvecWordT;

endpackage

//--- design/csrUnit.sv
module csrUnit #(
  parameter int FifoDepth = 4,
  parameter bit VirtMem   = 1'b1
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    cmdValid,
  output logic                    cmdReady,
  input  csrPkg::csrOpT           cmdOp,
  input  logic [11:0]             cmdAdr,
  input  csrPkg::privT            cmdPriv,
  input  logic [csrPkg::xlen-1:0] cmdData,
  input  logic [csrPkg::xlen-1:0] cmdCause,
  input  logic [csrPkg::xlen-1:0] cmdTval,
  input  logic                    statusTvm,
  output logic                    rspValid,
  input  logic                    rspReady,
  output logic [csrPkg::xlen-1:0] rspData,
  output logic                    rspIllegal
);
  import csrPkg::*;

  // Decoder to FIFO
  logic            decValid, decReady, decIllegal;
  csrOpT           decOp;
  regIdxT          decIdx;
  logic [xlen-1:0] decData, decCause, decTval;

  // FIFO to register file
  logic            fifoValid, fifoReady, fifoIllegal;
  csrOpT           fifoOp;
  regIdxT          fifoIdx;
  logic [xlen-1:0] fifoData, fifoCause, fifoTval;

  csrCmdDecode #(.VirtMem(VirtMem)) uDecode (
    .clk, .rstN, .cmdValid, .cmdReady, .cmdOp, .cmdAdr, .cmdPriv,
    .cmdData, .cmdCause, .cmdTval, .statusTvm,
    .decValid, .decReady, .decOp, .decIdx, .decIllegal, .decData, .decCause, .decTval
  );

  csrCmdFifo #(.FifoDepth(FifoDepth)) uFifo (
    .clk, .rstN,
    .decValid, .decReady, .decOp, .decIdx, .decIllegal, .decData, .decCause, .decTval,
    .fifoValid, .fifoReady, .fifoOp, .fifoIdx, .fifoIllegal, .fifoData, .fifoCause, .fifoTval
  );

  supervisorCsrs #(.VirtMem(VirtMem)) uCsrs (
    .clk, .rstN,
    .fifoValid, .fifoReady, .fifoOp, .fifoIdx, .fifoIllegal, .fifoData, .fifoCause, .fifoTval,
    .rspValid, .rspReady, .rspData, .rspIllegal
  );

endmodule

//--- design/supervisorCsrs.sv
module supervisorCsrs #(
  parameter bit VirtMem = 1'b1
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    fifoValid,
  output logic                    fifoReady,
  input  csrPkg::csrOpT           fifoOp,
  input  csrPkg::regIdxT          fifoIdx,
  input  logic                    fifoIllegal,
  input  logic [csrPkg::xlen-1:0] fifoData,
  input  logic [csrPkg::xlen-1:0] fifoCause,
  input  logic [csrPkg::xlen-1:0] fifoTval,
  output logic                    rspValid,
  input  logic                    rspReady,
  output logic [csrPkg::xlen-1:0] rspData,
  output logic                    rspIllegal
);
  import csrPkg::*;

  // Architectural state
  stvecWordT       stvec;
  logic [xlen-1:0] sscratch;
  logic [xlen-1:0] sepc;
  logic [xlen-1:0] scause;
  logic [xlen-1:0] stval;
  logic [xlen-1:0] satp;
  logic [31:0]     scounteren;
  logic [xlen-1:0] sedeleg;
  logic [xlen-1:0] sideleg;

  logic            pop;
  logic            isTrap;
  logic            wrAccess;
  logic [xlen-1:0] oldVal;
  logic [xlen-1:0] newVal;
  stvecWordT       stvecLegal;
  logic [xlen-1:0] trapTarget;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Take a new entry when the response slot frees up
  assign fifoReady = !rspValid || rspReady;
  assign pop       = fifoValid && fifoReady;
  assign isTrap    = (fifoOp == opTrap);
  assign wrAccess  = pop && !isTrap && !fifoIllegal;

  //////////////////////////////
  // Read and modify
  //////////////////////////////

  // Old value, zero for regNone
  always_comb begin
    case (fifoIdx)
      regStvec:      oldVal = stvec.raw;
      regSscratch:   oldVal = sscratch;
      regSepc:       oldVal = sepc;
      regScause:     oldVal = scause;
      regStval:      oldVal = stval;
      regSatp:       oldVal = satp;
      regScounteren: oldVal = {{(xlen-32){1'b0}}, scounteren};
      regSedeleg:    oldVal = sedeleg;
      regSideleg:    oldVal = sideleg;
      default:       oldVal = '0;
    endcase
  end

  always_comb begin
    case (fifoOp)
      opRw:    newVal = fifoData;
      opRs:    newVal = oldVal | fifoData;
      opRc:    newVal = oldVal & ~fifoData;
      default: newVal = oldVal;
    endcase
  end

  // Mode values 2 and 3 are reserved, drop the upper mode bit
  always_comb begin
    stvecLegal.raw       = newVal;
    stvecLegal.f.mode[1] = 1'b0;
  end

  // Direct mode jumps to base, vectored interrupts add 4 x cause
  always_comb begin
    trapTarget = {stvec.f.base, 2'b00};
    if (stvec.f.mode == 2'b01 && fifoCause[xlen-1]) begin
      trapTarget = trapTarget + {fifoCause[xlen-3:0], 2'b00};
    end
  end

  //////////////////////////////
  // Register updates
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      stvec      <= '0;
      sscratch   <= '0;
      sepc       <= '0;
      scause     <= '0;
      stval      <= '0;
      scounteren <= '0;
      sedeleg    <= '0;
      sideleg    <= '0;
    end else if (wrAccess) begin
      case (fifoIdx)
        regStvec:      stvec      <= stvecLegal;
        regSscratch:   sscratch   <= newVal;
        regSepc:       sepc       <= newVal;
        regScause:     scause     <= newVal;
        regStval:      stval      <= newVal;
        regScounteren: scounteren <= newVal[31:0];
        regSedeleg:    sedeleg    <= newVal & sedelegMask;
        regSideleg:    sideleg    <= newVal;
        default:       ;
      endcase
    end else if (pop && isTrap) begin
      // Trap entry, cmdData carries the faulting PC
      sepc   <= fifoData;
      scause <= fifoCause;
      stval  <= fifoTval;
    end
  end

  // Satp only exists with virtual memory
  if (VirtMem) begin : genSatp
    always_ff @(posedge clk) begin
      if (!rstN) begin
        satp <= '0;
      end else if (wrAccess && fifoIdx == regSatp) begin
        satp <= newVal;
      end
    end
  end else begin : genNoSatp
    assign satp = '0;
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rspValid <= 1'b0;
    end else if (pop) begin
      rspValid <= 1'b1;
    end else if (rspReady) begin
      rspValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      rspData    <= isTrap ? trapTarget : oldVal;
      rspIllegal <= fifoIllegal;
    end
  end

  // Held response must not change under back-pressure
  assert property (@(posedge clk) disable iff (!rstN)
    rspValid && !rspReady |=> rspValid && $stable(rspData));

endmodule

//--- verif/csrCases.txt
// op adr priv tvm data cause tval expData expIllegal
// op 0 rw, 1 rs, 2 rc, 3 trap; priv 0 U, 1 S, 3 M; a record with op f ends the list
1 140 1 0 0000000000000000 0 0 0000000000000000 0
0 140 1 0 123456789abcdef0 0 0 0000000000000000 0
1 140 1 0 000000000000000f 0 0 123456789abcdef0 0
2 140 1 0 000000000000ff00 0 0 123456789abcdeff 0
1 140 1 0 0000000000000000 0 0 123456789abc00ff 0
0 105 1 0 8000000000000103 0 0 0000000000000000 0
1 105 1 0 0000000000000000 0 0 8000000000000101 0
0 102 1 0 ffffffffffffffff 0 0 0000000000000000 0
1 102 1 0 0000000000000000 0 0 fffffffffffff1ff 0
0 106 1 0 ffffffff00000007 0 0 0000000000000000 0
1 106 1 0 0000000000000000 0 0 0000000000000007 0
0 7c0 1 0 000000000000ffff 0 0 0000000000000000 1
0 140 0 0 000000000000dead 0 0 0000000000000000 1
1 140 1 0 0000000000000000 0 0 123456789abc00ff 0
0 180 1 1 8000000000000000 0 0 0000000000000000 1
1 180 1 0 0000000000000000 0 0 0000000000000000 0
0 180 3 1 8000000000012345 0 0 0000000000000000 0
1 180 1 0 0000000000000000 0 0 8000000000012345 0
3 000 1 0 0000000080001000 000000000000000d 00000000deadbeef 8000000000000100 0
1 141 1 0 0000000000000000 0 0 0000000080001000 0
1 142 1 0 0000000000000000 0 0 000000000000000d 0
1 143 1 0 0000000000000000 0 0 00000000deadbeef 0
3 000 1 0 0000000080002000 8000000000000005 0 8000000000000114 0
1 142 1 0 0000000000000000 0 0 8000000000000005 0
0 105 1 0 0000000080000200 0 0 8000000000000101 0
3 000 0 0 0000000080003000 8000000000000009 0 0000000080000200 0
1 141 1 0 0000000000000000 0 0 0000000080003000 0
0 103 1 0 0000000000000222 0 0 0000000000000000 0
1 103 1 0 0000000000000000 0 0 0000000000000222 0
0 143 3 0 0000000000000001 0 0 0000000000000000 0
f 0 0 0 0 0 0 0 0

//--- verif/csrUnitTb.sv
module csrUnitTb;
  import csrPkg::*;

  localparam int RecWords  = 9;
  localparam int MaxCases  = 64;
  localparam int WaitLimit = 200;

  logic            clk;
  logic            rstN;
  logic            cmdValid;
  logic            cmdReady;
  csrOpT           cmdOp;
  logic [11:0]     cmdAdr;
  privT            cmdPriv;
  logic [xlen-1:0] cmdData;
  logic [xlen-1:0] cmdCause;
  logic [xlen-1:0] cmdTval;
  logic            statusTvm;
  logic            rspValid;
  logic            rspReady;
  logic [xlen-1:0] rspData;
  logic            rspIllegal;

  // Nine words per record, see the case file for the columns
  logic [63:0] caseMem [RecWords*MaxCases];
  int          numCases;
  int          mismatchCount;
  int          failCount;
  bit          aborted;
  logic [15:0] lfsr;

  tbClock #(.Period(4)) clkGen (.clk(clk));

  csrUnit #(.FifoDepth(4), .VirtMem(1'b1)) csrUnit_inst (
    .clk, .rstN, .cmdValid, .cmdReady, .cmdOp, .cmdAdr, .cmdPriv,
    .cmdData, .cmdCause, .cmdTval, .statusTvm,
    .rspValid, .rspReady, .rspData, .rspIllegal
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic checkValue(input int caseIdx, input string name,
                            input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s case %0d: expected %h, actual %h", name, caseIdx, expected, actual);
      mismatchCount++;
    end
  endtask

  // Records end at an op word of f
  task automatic loadCases();
    $readmemh("verif/csrCases.txt", caseMem);
    numCases = 0;
    while (numCases < MaxCases && caseMem[numCases*RecWords] != 64'hf) begin
      numCases++;
    end
  endtask

  //////////////////////////////
  // Driver and monitor
  //////////////////////////////

  // Called on a falling edge, each command held until accepted
  task automatic driveCommands();
    int idx;
    int base;
    int waited;
    idx = 0;
    while (idx < numCases && !aborted) begin
      base      = idx * RecWords;
      cmdValid  = 1'b1;
      cmdOp     = csrOpT'(caseMem[base][1:0]);
      cmdAdr    = caseMem[base+1][11:0];
      cmdPriv   = privT'(caseMem[base+2][1:0]);
      statusTvm = caseMem[base+3][0];
      cmdData   = caseMem[base+4];
      cmdCause  = caseMem[base+5];
      cmdTval   = caseMem[base+6];
      waited    = 0;
      // cmdReady only moves on rising edges
      while (!cmdReady && waited < WaitLimit) begin
        @(negedge clk);
        waited++;
      end
      if (!cmdReady) begin
        $display("Timeout: command %0d was never accepted", idx);
        failCount++;
        aborted = 1'b1;
      end else begin
        @(negedge clk);
        idx++;
      end
    end
    cmdValid = 1'b0;
  endtask

  // Responses must come back in record order
  task automatic collectResponses();
    int idx;
    int waited;
    bit got;
    idx = 0;
    while (idx < numCases && !aborted) begin
      waited = 0;
      got    = 1'b0;
      while (!got && !aborted && waited < WaitLimit) begin
        @(posedge clk);
        got = rspValid && rspReady;
        waited++;
      end
      if (got) begin
        checkValue(idx, "rspData", caseMem[idx*RecWords+7], rspData);
        checkValue(idx, "rspIllegal", caseMem[idx*RecWords+8], {63'b0, rspIllegal});
        idx++;
      end else if (!aborted) begin
        $display("Timeout: no response arrived for command %0d", idx);
        failCount++;
        aborted = 1'b1;
      end
    end
  endtask

  // Random back-pressure, one LFSR step per cycle from the first rising edge on
  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      lfsr     = lfsrStep(lfsr);
      rspReady = lfsr[0];
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rstN          = 1'b0;
    cmdValid      = 1'b0;
    cmdOp         = opRw;
    cmdAdr        = '0;
    cmdPriv       = privU;
    cmdData       = '0;
    cmdCause      = '0;
    cmdTval       = '0;
    statusTvm     = 1'b0;
    rspReady      = 1'b0;
    lfsr          = 16'd25897;
    mismatchCount = 0;
    failCount     = 0;
    aborted       = 1'b0;
    loadCases();
    if (numCases == 0) begin
      $display("The case file holds no records");
      failCount++;
    end
    // Ten rising edges in reset, release on the next falling edge
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    fork
      driveCommands();
      collectResponses();
    join
    $display("Checked %0d cases, mismatches %0d, other failures %0d",
             numCases, mismatchCount, failCount);
    if (mismatchCount == 0 && failCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verif/tbClock.sv
module tbClock #(
  parameter int Period = 4
) (
  output logic clk
);

  // Free running clock, starts low
  initial begin
    clk = 1'b0;
  end

  always begin
    #(Period / 2);
    clk = ~clk;
  end

endmodule
